/* hdl/usb_std_pkg.sv */
`default_nettype none

package usb_std_pkg;

  // SETUP packet as delivered by the protocol layer, endpoint in the top bits
  typedef struct packed {
    logic [3:0]  endpoint;
    logic [7:0]  bm_request_type;
    logic [7:0]  b_request;
    logic [15:0] w_value;
    logic [15:0] w_index;
    logic [15:0] w_length;
  } usb_setup_t;

  // Standard request codes handled on endpoint 0
  typedef enum logic [7:0] {
    SET_ADDRESS       = 8'd5,
    GET_DESCRIPTOR    = 8'd6,
    SET_CONFIGURATION = 8'd9
  } usb_request_e;

  // Descriptor types carried in the high byte of wValue
  typedef enum logic [7:0] {
    DEVICE = 8'd1,
    CONFIG = 8'd2,
    STRING = 8'd3
  } usb_desc_type_e;

  // Type code of an interface descriptor inside the configuration bundle
  localparam logic [7:0] INTERFACE_DESC_TYPE = 8'h04;

  // bmRequestType fields
  localparam logic [1:0] REQ_TYPE_STANDARD = 2'b00;
  localparam logic [4:0] RECIPIENT_DEVICE  = 5'b00000;

  // bcdUSB values
  localparam logic [15:0] BCD_USB_20 = 16'h0200;
  localparam logic [15:0] BCD_USB_11 = 16'h0110;

  // Endpoint 0 packet size reported in the device descriptor
  localparam logic [7:0] EP0_MAX_PACKET = 8'h40;

  // US English, the only supported language
  localparam logic [15:0] LANG_ID_EN_US = 16'h0409;

  // Descriptor lengths in bytes
  localparam int DEVICE_DESC_LEN    = 18;
  localparam int CONFIG_HDR_LEN     = 9;
  localparam int INTERFACE_DESC_LEN = 9;
  localparam int CONFIG_DESC_LEN    = CONFIG_HDR_LEN + INTERFACE_DESC_LEN;
  localparam int LANG_DESC_LEN      = 4;

endpackage

`default_nettype wire

/* hdl/ep0_cfg_pkg.sv */
`default_nettype none

package ep0_cfg_pkg;

  // Decoded request classes, encoding follows the legacy core
  typedef enum logic [2:0] {
    NONE,
    GET_DEVICE,
    SET_ADDRESS,
    GET_CONFIG,
    SET_CONFIG,
    GET_STRING
  } req_kind_e;

  // Control engine states
  typedef enum logic [1:0] {
    IDLE,
    GET_DESC,
    SET_ADDR,
    SET_CONF
  } ctl_state_e;

  // Device state seen by the CPU, refused is a one-cycle pulse
  typedef struct packed {
    logic [6:0] device_address;
    logic [7:0] current_configuration;
    logic       configured;
    logic       refused;
  } ep0_status_t;

  // ROM layout: device, configuration, language, product string
  localparam int CONFIG_OFFSET  = usb_std_pkg::DEVICE_DESC_LEN;
  localparam int LANG_OFFSET    = CONFIG_OFFSET + usb_std_pkg::CONFIG_DESC_LEN;
  localparam int PRODUCT_OFFSET = LANG_OFFSET + usb_std_pkg::LANG_DESC_LEN;

  // String index reported as iProduct
  localparam logic [7:0] PRODUCT_STR_INDEX = 8'd2;

  // UTF-16 string descriptor, two header bytes plus two per character
  function automatic int string_desc_len(int num_chars);
    return 2 + 2 * num_chars;
  endfunction

  // Bytes in use, the string block is dropped when there is no product text
  function automatic int rom_size(int product_len);
    return (product_len > 0) ? PRODUCT_OFFSET + string_desc_len(product_len) : LANG_OFFSET;
  endfunction

endpackage

`default_nettype wire

/* hdl/setup_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module setup_decoder #(
  parameter int PRODUCT_LEN = 0,
  parameter int ROM_AW      = 6
) (
  input  usb_std_pkg::usb_setup_t setup_i,
  output ep0_cfg_pkg::req_kind_e  req_kind_o,
  output logic [ROM_AW-1:0]       start_addr_o
);

  logic       std_dev_req;
  logic [7:0] desc_type;
  logic [7:0] desc_index;

  // Standard request aimed at the device itself on endpoint 0
  assign std_dev_req = (setup_i.endpoint == 4'h0) &&
                       (setup_i.bm_request_type[6:5] == usb_std_pkg::REQ_TYPE_STANDARD) &&
                       (setup_i.bm_request_type[4:0] == usb_std_pkg::RECIPIENT_DEVICE);

  assign desc_type  = setup_i.w_value[15:8];
  assign desc_index = setup_i.w_value[7:0];

  always_comb begin
    req_kind_o   = ep0_cfg_pkg::NONE;
    start_addr_o = '0;
    if (std_dev_req) begin
      case (setup_i.b_request)
        usb_std_pkg::GET_DESCRIPTOR: begin
          case (desc_type)
            usb_std_pkg::DEVICE: req_kind_o = ep0_cfg_pkg::GET_DEVICE;
            usb_std_pkg::CONFIG: begin
              req_kind_o   = ep0_cfg_pkg::GET_CONFIG;
              start_addr_o = ROM_AW'(ep0_cfg_pkg::CONFIG_OFFSET);
            end
            usb_std_pkg::STRING: begin
              // Index 0 is the language list
              if (PRODUCT_LEN > 0 && desc_index == 8'd0) begin
                req_kind_o   = ep0_cfg_pkg::GET_STRING;
                start_addr_o = ROM_AW'(ep0_cfg_pkg::LANG_OFFSET);
              end else if (PRODUCT_LEN > 0 && desc_index == ep0_cfg_pkg::PRODUCT_STR_INDEX) begin
                req_kind_o   = ep0_cfg_pkg::GET_STRING;
                start_addr_o = ROM_AW'(ep0_cfg_pkg::PRODUCT_OFFSET);
              end
            end
            default: req_kind_o = ep0_cfg_pkg::NONE;
          endcase
        end
        usb_std_pkg::SET_ADDRESS:       req_kind_o = ep0_cfg_pkg::SET_ADDRESS;
        usb_std_pkg::SET_CONFIGURATION: req_kind_o = ep0_cfg_pkg::SET_CONFIG;
        default:                        req_kind_o = ep0_cfg_pkg::NONE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/descriptor_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module descriptor_rom #(
  parameter logic [15:0] VENDOR_ID   = 16'hFACE,
  parameter logic [15:0] PRODUCT_ID  = 16'h0BDE,
  parameter bit          HIGH_SPEED  = 1'b1,
  parameter int          PRODUCT_LEN = 0,
  parameter              PRODUCT_STR = "",
  parameter int          ROM_AW      = 6
) (
  input  logic [ROM_AW-1:0] addr_i,
  output logic [7:0]        data_o,
  output logic              last_o
);

  localparam int ROM_DEPTH = 2 ** ROM_AW;
  localparam int DEV_LEN   = usb_std_pkg::DEVICE_DESC_LEN;
  localparam int CFG_LEN   = usb_std_pkg::CONFIG_DESC_LEN;
  localparam int LANG_LEN  = usb_std_pkg::LANG_DESC_LEN;
  localparam int PROD_LEN  = ep0_cfg_pkg::string_desc_len(PRODUCT_LEN);

  localparam logic [15:0] BCD_USB = HIGH_SPEED ? usb_std_pkg::BCD_USB_20 : usb_std_pkg::BCD_USB_11;
  localparam logic [7:0]  I_PRODUCT = (PRODUCT_LEN > 0) ? ep0_cfg_pkg::PRODUCT_STR_INDEX : 8'h00;

  // Byte 0 sits in the low bits, multi-byte fields are little endian
  localparam logic [8*DEV_LEN-1:0] DEVICE_DESC = {
    8'h01, 8'h00, I_PRODUCT, 8'h00,
    16'h0000, PRODUCT_ID, VENDOR_ID,
    usb_std_pkg::EP0_MAX_PACKET, 8'h00, 8'h00, 8'hFF,
    BCD_USB, usb_std_pkg::DEVICE, 8'(DEV_LEN)
  };

  // One configuration with a single interface and no extra endpoints
  localparam logic [8*CFG_LEN-1:0] CONFIG_DESC = {
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
    usb_std_pkg::INTERFACE_DESC_TYPE, 8'(usb_std_pkg::INTERFACE_DESC_LEN),
    8'h32, 8'hC0, 8'h00, 8'h01, 8'h01,
    16'(CFG_LEN), usb_std_pkg::CONFIG, 8'(usb_std_pkg::CONFIG_HDR_LEN)
  };

  localparam logic [8*LANG_LEN-1:0] LANG_DESC = {
    usb_std_pkg::LANG_ID_EN_US, usb_std_pkg::STRING, 8'(LANG_LEN)
  };

  // ASCII text widened to UTF-16, first character first
  function automatic logic [8*PROD_LEN-1:0] product_desc();
    logic [8*PROD_LEN-1:0] d;
    d = '0;
    d[7:0]  = 8'(PROD_LEN);
    d[15:8] = usb_std_pkg::STRING;
    for (int i = 0; i < PRODUCT_LEN; i++) begin
      d[8*(2+2*i) +: 8] = PRODUCT_STR[8*(PRODUCT_LEN-1-i) +: 8];
    end
    return d;
  endfunction

  function automatic logic [8*ROM_DEPTH-1:0] build_image();
    logic [8*ROM_DEPTH-1:0] img;
    img = '0;
    img[0 +: 8*DEV_LEN] = DEVICE_DESC;
    img[8*ep0_cfg_pkg::CONFIG_OFFSET +: 8*CFG_LEN] = CONFIG_DESC;
    if (PRODUCT_LEN > 0) begin
      img[8*ep0_cfg_pkg::LANG_OFFSET +: 8*LANG_LEN] = LANG_DESC;
      img[8*ep0_cfg_pkg::PRODUCT_OFFSET +: 8*PROD_LEN] = product_desc();
    end
    return img;
  endfunction

  // Final byte of every descriptor
  function automatic logic [ROM_DEPTH-1:0] build_last();
    logic [ROM_DEPTH-1:0] marks;
    marks = '0;
    marks[DEV_LEN-1] = 1'b1;
    marks[ep0_cfg_pkg::CONFIG_OFFSET+CFG_LEN-1] = 1'b1;
    if (PRODUCT_LEN > 0) begin
      marks[ep0_cfg_pkg::LANG_OFFSET+LANG_LEN-1]   = 1'b1;
      marks[ep0_cfg_pkg::PRODUCT_OFFSET+PROD_LEN-1] = 1'b1;
    end
    return marks;
  endfunction

  localparam logic [8*ROM_DEPTH-1:0] ROM_IMAGE = build_image();
  localparam logic [ROM_DEPTH-1:0]   LAST_MAP  = build_last();

  // Unused locations read as zero with no last mark
  assign data_o = ROM_IMAGE[8*addr_i +: 8];
  assign last_o = LAST_MAP[addr_i];

endmodule

`default_nettype wire

/* hdl/ep0_control.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_control #(
  parameter int ROM_AW = 6
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     xfer_req_i,
  input  usb_std_pkg::usb_setup_t  setup_i,
  input  ep0_cfg_pkg::req_kind_e   req_kind_i,
  input  logic [ROM_AW-1:0]        start_addr_i,
  input  logic [7:0]               rom_data_i,
  input  logic                     rom_last_i,
  output logic [ROM_AW-1:0]        rom_addr_o,
  output logic                     xfer_gnt_o,
  output logic                     tvalid_o,
  output logic                     tlast_o,
  output logic [7:0]               tdata_o,
  input  logic                     tready_i,
  output ep0_cfg_pkg::ep0_status_t status_o
);

  ep0_cfg_pkg::ctl_state_e state_q;
  logic [ROM_AW-1:0]       ptr_q;
  logic                    gnt_q;
  logic                    req_q;
  logic [6:0]              dev_addr_q;
  logic [6:0]              pend_addr_q;
  logic [7:0]              cfg_q;
  logic                    configured_q;
  logic                    accept;
  logic                    refused;

  assign accept  = (state_q == ep0_cfg_pkg::IDLE) && xfer_req_i &&
                   (req_kind_i != ep0_cfg_pkg::NONE);
  // First cycle of a request nobody will answer
  assign refused = (state_q == ep0_cfg_pkg::IDLE) && xfer_req_i && !req_q &&
                   (req_kind_i == ep0_cfg_pkg::NONE);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= ep0_cfg_pkg::IDLE;
      ptr_q        <= '0;
      gnt_q        <= 1'b0;
      req_q        <= 1'b0;
      dev_addr_q   <= '0;
      cfg_q        <= '0;
      configured_q <= 1'b0;
    end else begin
      gnt_q <= xfer_req_i && (req_kind_i != ep0_cfg_pkg::NONE);
      req_q <= xfer_req_i;
      case (state_q)
        ep0_cfg_pkg::IDLE: begin
          if (accept) begin
            case (req_kind_i)
              ep0_cfg_pkg::SET_ADDRESS: state_q <= ep0_cfg_pkg::SET_ADDR;
              ep0_cfg_pkg::SET_CONFIG: begin
                cfg_q   <= setup_i.w_value[7:0];
                state_q <= ep0_cfg_pkg::SET_CONF;
              end
              default: begin
                ptr_q   <= start_addr_i;
                state_q <= ep0_cfg_pkg::GET_DESC;
              end
            endcase
          end
        end
        ep0_cfg_pkg::GET_DESC: begin
          if (!xfer_req_i) begin
            state_q <= ep0_cfg_pkg::IDLE;
          end else if (tready_i) begin
            ptr_q <= ptr_q + 1'b1;
          end
        end
        // New address only after the status stage
        ep0_cfg_pkg::SET_ADDR: begin
          if (!xfer_req_i) begin
            dev_addr_q <= pend_addr_q;
            state_q    <= ep0_cfg_pkg::IDLE;
          end
        end
        ep0_cfg_pkg::SET_CONF: begin
          if (!xfer_req_i) begin
            configured_q <= 1'b1;
            state_q      <= ep0_cfg_pkg::IDLE;
          end
        end
        default: state_q <= ep0_cfg_pkg::IDLE;
      endcase
    end
  end

  // Captured at acceptance, setup may change once the request drops
  always_ff @(posedge clock) begin
    if (accept && req_kind_i == ep0_cfg_pkg::SET_ADDRESS) begin
      pend_addr_q <= setup_i.w_value[6:0];
    end
  end

  assign rom_addr_o = ptr_q;
  assign xfer_gnt_o = gnt_q;
  assign tvalid_o   = (state_q == ep0_cfg_pkg::GET_DESC);
  assign tdata_o    = rom_data_i;
  assign tlast_o    = rom_last_i;

  assign status_o = '{
    device_address:        dev_addr_q,
    current_configuration: cfg_q,
    configured:            configured_q,
    refused:               refused
  };

endmodule

`default_nettype wire

/* hdl/ep0_status_apb.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_status_apb (
  input  logic                     clock,
  input  logic                     reset,
  input  ep0_cfg_pkg::ep0_status_t status_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [3:0]               paddr_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o
);

  // Register offsets
  localparam logic [3:0] REG_ADDRESS    = 4'h0;
  localparam logic [3:0] REG_CONFIG     = 4'h4;
  localparam logic [3:0] REG_CONFIGURED = 4'h8;
  localparam logic [3:0] REG_REFUSED    = 4'hC;

  logic [15:0] refused_cnt_q;
  logic [31:0] rd_data;
  logic        bad_addr;

  // Saturating count of refused requests
  always_ff @(posedge clock) begin
    if (reset) begin
      refused_cnt_q <= '0;
    end else if (status_i.refused && refused_cnt_q != 16'hFFFF) begin
      refused_cnt_q <= refused_cnt_q + 16'd1;
    end
  end

  always_comb begin
    bad_addr = 1'b0;
    case (paddr_i)
      REG_ADDRESS:    rd_data = 32'(status_i.device_address);
      REG_CONFIG:     rd_data = 32'(status_i.current_configuration);
      REG_CONFIGURED: rd_data = 32'(status_i.configured);
      REG_REFUSED:    rd_data = 32'(refused_cnt_q);
      default: begin
        rd_data  = '0;
        bad_addr = 1'b1;
      end
    endcase
  end

  // Read-only block, no wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i && penable_i && (pwrite_i || bad_addr);
  assign prdata_o  = (pwrite_i || bad_addr) ? 32'd0 : rd_data;

endmodule

`default_nettype wire

/* hdl/ep0_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_top #(
  parameter logic [15:0] VENDOR_ID   = 16'hFACE,
  parameter logic [15:0] PRODUCT_ID  = 16'h0BDE,
  parameter bit          HIGH_SPEED  = 1'b1,
  parameter int          PRODUCT_LEN = 7,
  parameter              PRODUCT_STR = "EP0 USB"
) (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_std_pkg::usb_setup_t setup_i,
  input  logic                    xfer_req_i,
  output logic                    xfer_gnt_o,
  output logic [7:0]              tdata_o,
  output logic                    tvalid_o,
  output logic                    tlast_o,
  input  logic                    tready_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [3:0]              paddr_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  // ROM address width covers every descriptor in use
  localparam int ROM_AW = $clog2(ep0_cfg_pkg::rom_size(PRODUCT_LEN));

  ep0_cfg_pkg::req_kind_e   req_kind;
  ep0_cfg_pkg::ep0_status_t status;
  logic [ROM_AW-1:0]        start_addr;
  logic [ROM_AW-1:0]        rom_addr;
  logic [7:0]               rom_data;
  logic                     rom_last;

  setup_decoder #(
    .PRODUCT_LEN (PRODUCT_LEN),
    .ROM_AW      (ROM_AW)
  ) u_decoder (
    .setup_i      (setup_i),
    .req_kind_o   (req_kind),
    .start_addr_o (start_addr)
  );

  descriptor_rom #(
    .VENDOR_ID   (VENDOR_ID),
    .PRODUCT_ID  (PRODUCT_ID),
    .HIGH_SPEED  (HIGH_SPEED),
    .PRODUCT_LEN (PRODUCT_LEN),
    .PRODUCT_STR (PRODUCT_STR),
    .ROM_AW      (ROM_AW)
  ) u_rom (
    .addr_i (rom_addr),
    .data_o (rom_data),
    .last_o (rom_last)
  );

  ep0_control #(
    .ROM_AW (ROM_AW)
  ) u_control (
    .clock        (clock),
    .reset        (reset),
    .xfer_req_i   (xfer_req_i),
    .setup_i      (setup_i),
    .req_kind_i   (req_kind),
    .start_addr_i (start_addr),
    .rom_data_i   (rom_data),
    .rom_last_i   (rom_last),
    .rom_addr_o   (rom_addr),
    .xfer_gnt_o   (xfer_gnt_o),
    .tvalid_o     (tvalid_o),
    .tlast_o      (tlast_o),
    .tdata_o      (tdata_o),
    .tready_i     (tready_i),
    .status_o     (status)
  );

  ep0_status_apb u_status (
    .clock     (clock),
    .reset     (reset),
    .status_i  (status),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

endmodule

`default_nettype wire

/* sim/ep0_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_assert (
  input logic       clock,
  input logic       reset,
  input logic       xfer_req_i,
  input logic       xfer_gnt_i,
  input logic       tvalid_i,
  input logic       tready_i,
  input logic [7:0] tdata_i,
  input logic       tlast_i
);

  int error_count;

  initial begin
    error_count = 0;
  end

  // Grant is registered from the request of the previous cycle
  grant_after_request: assert property (
    @(posedge clock) disable iff (reset) xfer_gnt_i |-> $past(xfer_req_i)
  ) else begin
    error_count = error_count + 1;
    $error("grant raised without a request on the previous cycle");
  end

  // Back-pressure freezes the byte stream
  data_held_on_stall: assert property (
    @(posedge clock) disable iff (reset)
      (tvalid_i && !tready_i) |=> ($stable(tdata_i) && $stable(tlast_i))
  ) else begin
    error_count = error_count + 1;
    $error("tdata or tlast changed while tvalid was high and tready low");
  end

  valid_low_after_reset: assert property (
    @(posedge clock) reset |=> !tvalid_i
  ) else begin
    error_count = error_count + 1;
    $error("tvalid high in the cycle after reset");
  end

endmodule

bind ep0_control ep0_assert u_assert (
  .clock      (clock),
  .reset      (reset),
  .xfer_req_i (xfer_req_i),
  .xfer_gnt_i (xfer_gnt_o),
  .tvalid_i   (tvalid_o),
  .tready_i   (tready_i),
  .tdata_i    (tdata_o),
  .tlast_i    (tlast_o)
);

`default_nettype wire

/* sim/ep0_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_checker (
  input logic        clock,
  input logic        xfer_gnt_i,
  input logic [7:0]  tdata_i,
  input logic        tvalid_i,
  input logic        tlast_i,
  input logic        tready_i,
  input logic        psel_i,
  input logic        penable_i,
  input logic        pready_i,
  input logic [31:0] prdata_i,
  input logic        pslverr_i
);

  string       test_name;
  logic        test_failed;
  int          pass_count;
  int          fail_count;
  logic [7:0]  bytes_q[$];
  logic        last_q[$];
  logic        gnt_seen;
  logic        apb_seen;
  logic [31:0] apb_data;
  logic        apb_err;

  initial begin
    test_name   = "";
    test_failed = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    gnt_seen    = 1'b0;
    apb_seen    = 1'b0;
    apb_data    = '0;
    apb_err     = 1'b0;
  end

  // Sampled mid-cycle, away from both clock edges
  always @(negedge clock) begin
    if (tvalid_i && tready_i) begin
      bytes_q.push_back(tdata_i);
      last_q.push_back(tlast_i);
    end
    if (xfer_gnt_i) begin
      gnt_seen = 1'b1;
    end
    if (psel_i && penable_i && pready_i) begin
      apb_seen = 1'b1;
      apb_data = prdata_i;
      apb_err  = pslverr_i;
    end
  end

  task automatic open_test(string name);
    test_name   = name;
    test_failed = 1'b0;
    bytes_q.delete();
    last_q.delete();
    gnt_seen = 1'b0;
    apb_seen = 1'b0;
  endtask

  task automatic report_problem(string what);
    test_failed = 1'b1;
    $display("%s: %s", test_name, what);
  endtask

  task automatic mismatch(string what, logic [31:0] expected, logic [31:0] actual);
    test_failed = 1'b1;
    $display("Fail %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
  endtask

  task automatic verify_grant(logic expected);
    if (gnt_seen !== expected) begin
      mismatch("grant", 32'(expected), 32'(gnt_seen));
    end
  endtask

  // Expected bytes arrive first byte in the top bits
  task automatic compare_bytes(int count, logic [255:0] expected);
    int         i;
    logic [7:0] want;
    logic       want_last;
    verify_grant(1'b1);
    if (bytes_q.size() != count) begin
      mismatch("byte count", count, bytes_q.size());
    end else begin
      for (i = 0; i < count; i++) begin
        want      = expected[8*(count-1-i) +: 8];
        want_last = (i == count - 1);
        if (bytes_q[i] !== want) begin
          mismatch($sformatf("byte %0d", i), want, bytes_q[i]);
        end
        if (last_q[i] !== want_last) begin
          mismatch($sformatf("tlast at byte %0d", i), want_last, last_q[i]);
        end
      end
    end
  endtask

  task automatic compare_read(logic [31:0] exp_data, logic exp_err);
    if (!apb_seen) begin
      report_problem("the APB access phase never completed");
    end else begin
      if (apb_err !== exp_err) begin
        mismatch("pslverr", 32'(exp_err), 32'(apb_err));
      end
      if (apb_data !== exp_data) begin
        mismatch("prdata", exp_data, apb_data);
      end
    end
    apb_seen = 1'b0;
  endtask

  task automatic close_test();
    if (test_failed) begin
      fail_count++;
      $display("%s: failed", test_name);
    end else begin
      pass_count++;
      $display("%s: passed", test_name);
    end
  endtask

  task automatic print_totals();
    $display("Tests run %0d, passed %0d, failed %0d",
             pass_count + fail_count, pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

/* sim/ep0_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ep0_tb;

  localparam int MAX_TESTS    = 32;
  localparam int RESET_CYCLES = 8;
  localparam     STIM_FILE    = "sim/ep0_stimulus.txt";

  logic                    clock;
  logic                    reset;
  usb_std_pkg::usb_setup_t setup;
  logic                    xfer_req;
  logic                    xfer_gnt;
  logic [7:0]              tdata;
  logic                    tvalid;
  logic                    tlast;
  logic                    tready;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [3:0]              paddr;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;

  // One entry per stimulus line
  string        name_tbl[MAX_TESTS];
  string        kind_tbl[MAX_TESTS];
  logic [7:0]   arg1_tbl[MAX_TESTS];
  logic [7:0]   arg2_tbl[MAX_TESTS];
  logic [15:0]  arg3_tbl[MAX_TESTS];
  logic [15:0]  arg4_tbl[MAX_TESTS];
  int           count_tbl[MAX_TESTS];
  logic [255:0] expect_tbl[MAX_TESTS];
  int           num_tests;

  logic [15:0] lfsr_q;
  int          cycle_count;
  int          cycle_limit;

  ep0_top dut (
    .clock      (clock),
    .reset      (reset),
    .setup_i    (setup),
    .xfer_req_i (xfer_req),
    .xfer_gnt_o (xfer_gnt),
    .tdata_o    (tdata),
    .tvalid_o   (tvalid),
    .tlast_o    (tlast),
    .tready_i   (tready),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr)
  );

  ep0_checker u_checker (
    .clock      (clock),
    .xfer_gnt_i (xfer_gnt),
    .tdata_i    (tdata),
    .tvalid_i   (tvalid),
    .tlast_i    (tlast),
    .tready_i   (tready),
    .psel_i     (psel),
    .penable_i  (penable),
    .pready_i   (pready),
    .prdata_i   (prdata),
    .pslverr_i  (pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic random_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out;
  endfunction

  // Stall about one cycle in four
  function automatic logic pick_ready();
    logic b0;
    logic b1;
    b0 = random_bit();
    b1 = random_bit();
    return !(b0 && b1);
  endfunction

  function automatic usb_std_pkg::usb_setup_t make_setup(int i);
    usb_std_pkg::usb_setup_t s;
    s.endpoint        = 4'h0;
    s.bm_request_type = arg1_tbl[i];
    s.b_request       = arg2_tbl[i];
    s.w_value         = arg3_tbl[i];
    s.w_index         = arg4_tbl[i];
    s.w_length        = 16'(count_tbl[i]);
    return s;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic load_stimulus(output logic ok);
    int           fd;
    int           n;
    int           rc;
    string        line;
    string        name;
    string        kind;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [15:0]  a3;
    logic [15:0]  a4;
    int           cnt;
    logic [255:0] exp_bytes;
    num_tests = 0;
    ok        = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line = "";
        rc   = $fgets(line, fd);
        if (rc > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h %d %h",
                      name, kind, a1, a2, a3, a4, cnt, exp_bytes);
          if (n == 8) begin
            name_tbl[num_tests]   = name;
            kind_tbl[num_tests]   = kind;
            arg1_tbl[num_tests]   = a1;
            arg2_tbl[num_tests]   = a2;
            arg3_tbl[num_tests]   = a3;
            arg4_tbl[num_tests]   = a4;
            count_tbl[num_tests]  = cnt;
            expect_tbl[num_tests] = exp_bytes;
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_grant(int limit);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit) begin
      @(negedge clock);
      seen = xfer_gnt;
      waited++;
    end
    next_cycle();
  endtask

  task automatic apb_access(logic [3:0] addr, logic write);
    int   waited;
    logic done;
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    waited  = 0;
    done    = 1'b0;
    while (!done && waited < 4) begin
      @(negedge clock);
      done = pready;
      waited++;
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Requester side of a GET_DESCRIPTOR that counts bytes up to tlast
  task automatic transfer_descriptor(int i);
    logic done;
    next_cycle();
    setup    = make_setup(i);
    xfer_req = 1'b1;
    tready   = pick_ready();
    done     = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = tvalid && tready && tlast;
      next_cycle();
      if (!done) begin
        tready = pick_ready();
      end
    end
    // The stream runs on until the control engine sees the request drop
    xfer_req = 1'b0;
    tready   = 1'b0;
    next_cycle();
    u_checker.compare_bytes(count_tbl[i], expect_tbl[i]);
  endtask

  task automatic control_request(int i);
    next_cycle();
    setup    = make_setup(i);
    xfer_req = 1'b1;
    wait_grant(8);
    u_checker.verify_grant(1'b1);
    // Status stage still pending so the old address reads back
    apb_access(4'h0, 1'b0);
    u_checker.compare_read(expect_tbl[i][31:0], 1'b0);
    xfer_req = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic refused_request(int i);
    next_cycle();
    setup    = make_setup(i);
    xfer_req = 1'b1;
    wait_grant(8);
    u_checker.verify_grant(1'b0);
    xfer_req = 1'b0;
  endtask

  task automatic register_access(int i);
    apb_access(arg1_tbl[i][3:0], kind_tbl[i] == "W");
    u_checker.compare_read(expect_tbl[i][31:0], arg2_tbl[i][0]);
  endtask

  initial begin : stimulus_run
    logic loaded;
    int   i;
    reset       = 1'b1;
    setup       = '0;
    xfer_req    = 1'b0;
    tready      = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    lfsr_q      = 16'd1998;
    cycle_count = 0;
    cycle_limit = 0;
    load_stimulus(loaded);
    if (!loaded) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      cycle_limit = RESET_CYCLES;
      for (i = 0; i < num_tests; i++) begin
        cycle_limit = cycle_limit + 4 * count_tbl[i] + 20;
      end
      repeat (RESET_CYCLES) @(posedge clock);
      #1;
      reset = 1'b0;
      for (i = 0; i < num_tests; i++) begin
        u_checker.open_test(name_tbl[i]);
        if (kind_tbl[i] == "G") begin
          transfer_descriptor(i);
        end else if (kind_tbl[i] == "S") begin
          control_request(i);
        end else if (kind_tbl[i] == "R") begin
          refused_request(i);
        end else if (kind_tbl[i] == "A" || kind_tbl[i] == "W") begin
          register_access(i);
        end else begin
          u_checker.report_problem($sformatf("unknown test kind %s", kind_tbl[i]));
        end
        u_checker.close_test();
      end
      repeat (2) next_cycle();
      u_checker.print_totals();
      if (num_tests > 0 && u_checker.fail_count == 0 &&
          dut.u_control.u_assert.error_count == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/ep0_stimulus.txt */
# name kind c1 c2 c3 c4 count expect   (c1-c4 and expect hex, count decimal)
# G S R: c1 bmRequestType c2 bRequest c3 wValue c4 wIndex, G expect = bytes first byte leftmost
# S expect = register 0 read while the request is held; A W: c1 APB address c2 pslverr
get_device       G 80 06 0100 0000 18 12010002ff000040cefade0b000000020001
get_config       G 80 06 0200 0000 18 09021200010100c032090400000000000000
get_lang         G 80 06 0300 0000 4  04030904
get_product      G 80 06 0302 0409 16 10034500500030002000550053004200
set_address      S 00 05 002a 0000 0  0
read_address     A 0  0  0000 0000 0  2a
set_config       S 00 09 0001 0000 0  2a
read_config      A 4  0  0000 0000 0  1
read_configured  A 8  0  0000 0000 0  1
vendor_req       R 40 01 0000 0000 0  0
bad_string_index R 80 06 0305 0000 0  0
read_refused     A c  0  0000 0000 0  2
apb_write        W 0  1  0000 0000 0  0
apb_bad_addr     A e  1  0000 0000 0  0

/* src.f */
hdl/usb_std_pkg.sv
hdl/ep0_cfg_pkg.sv
hdl/setup_decoder.sv
hdl/descriptor_rom.sv
hdl/ep0_control.sv
hdl/ep0_status_apb.sv
hdl/ep0_top.sv
sim/ep0_assert.sv
sim/ep0_checker.sv
sim/ep0_tb.sv

/* Bender.yml */
package:
  name: usb_ep0

sources:
  - hdl/usb_std_pkg.sv
  - hdl/ep0_cfg_pkg.sv
  - hdl/setup_decoder.sv
  - hdl/descriptor_rom.sv
  - hdl/ep0_control.sv
  - hdl/ep0_status_apb.sv
  - hdl/ep0_top.sv
  - target: simulation
    files:
      - sim/ep0_assert.sv
      - sim/ep0_checker.sv
      - sim/ep0_tb.sv
